//--- design/mmu_macros.svh
`ifndef MMU_MACROS_SVH
`define MMU_MACROS_SVH

// Address and PTE width for RV32
`define MMU_XLEN       32

// Virtual address layout
// VPN[1] sits above VPN[0], each one index into a 1024 entry table
`define MMU_VPN_W      10
`define MMU_OFFSET_W   12

// PPN field of a PTE occupies the top bits
`define MMU_PPN_W      22

// PTEs are four bytes apart
`define MMU_PTE_SHIFT  2

// PTE flag bit positions
`define MMU_PTE_V      0
`define MMU_PTE_R      1
`define MMU_PTE_W      2
`define MMU_PTE_X      3
`define MMU_PTE_U      4

// A and D bits live at 6 and 7 and are ignored by the walker

`endif

//--- design/mmu_pkg.sv
package mmu_pkg;

    // Walker state
    typedef enum logic [1:0] {
        IDLE,
        LEVEL1_WAIT,
        LEVEL2_WAIT,
        FAULT
    } ptw_state_e;

    // Privilege levels, encoded as in mstatus.MPP
    typedef enum logic [1:0] {
        PRIV_U = 2'd0,
        PRIV_S = 2'd1,
        PRIV_M = 2'd3
    } priv_e;

    // RISC-V exception causes for page faults
    typedef enum logic [3:0] {
        FAULT_INST  = 4'd12,
        FAULT_LOAD  = 4'd13,
        FAULT_STORE = 4'd15
    } fault_code_e;

    // Source of the page table read address
    typedef enum logic [1:0] {
        ROOT_LIVE,
        ROOT_SAVED,
        NEXT_LIVE,
        NEXT_SAVED
    } ptw_addr_sel_e;

    // Shape of the translated address
    typedef enum logic [1:0] {
        PADDR_BARE,
        PADDR_SUPER,
        PADDR_PAGE
    } paddr_sel_e;

endpackage

//--- design/pte_checker.sv
`timescale 1ns/1ps

`include "mmu_macros.svh"

module pte_checker
    import mmu_pkg::*;
(
    input  logic [`MMU_XLEN-1:0] pte_i,
    input  logic                 level2_i,
    input  priv_e                priv_i,
    input  logic                 is_write_i,
    input  logic                 is_execute_i,
    output logic                 pte_leaf_o,
    output logic                 pte_fault_o
);

    // PPN starts right above the flag and RSW bits
    localparam int PPN_LSB = `MMU_XLEN - `MMU_PPN_W;

    logic v_bit;
    logic r_bit;
    logic w_bit;
    logic x_bit;
    logic u_bit;
    logic leaf;
    logic is_load;
    logic misaligned;
    logic perm_fault;

    assign v_bit = pte_i[`MMU_PTE_V];
    assign r_bit = pte_i[`MMU_PTE_R];
    assign w_bit = pte_i[`MMU_PTE_W];
    assign x_bit = pte_i[`MMU_PTE_X];
    assign u_bit = pte_i[`MMU_PTE_U];

    // Leaf once any of R or X is set, otherwise a pointer
    assign leaf       = r_bit | x_bit;
    assign pte_leaf_o = leaf;

    // Superpage needs PPN[0] all zero
    assign misaligned = |pte_i[PPN_LSB +: `MMU_VPN_W];

    assign is_load = !is_write_i && !is_execute_i;

    // Permission checks, S mode reaches U pages freely
    always_comb begin
        perm_fault = 1'b0;
        // Reserved encoding
        if (w_bit && !r_bit)
            perm_fault = 1'b1;
        if (priv_i == PRIV_U && !u_bit)
            perm_fault = 1'b1;
        if (is_load && !r_bit)
            perm_fault = 1'b1;
        if (is_write_i && !w_bit)
            perm_fault = 1'b1;
        if (is_execute_i && !x_bit)
            perm_fault = 1'b1;
    end

    // Structural checks first, permissions only on leaves
    always_comb begin
        if (!v_bit)
            pte_fault_o = 1'b1;
        else if (!leaf)
            pte_fault_o = level2_i;
        else if (!level2_i && misaligned)
            pte_fault_o = 1'b1;
        else
            pte_fault_o = perm_fault;
    end

endmodule

//--- design/ptw_fsm.sv
`timescale 1ns/1ps

`include "mmu_macros.svh"

module ptw_fsm
    import mmu_pkg::*;
(
    input  logic          clk,
    input  logic          rst,
    input  logic          translate_req_i,
    input  logic          paging_enabled_i,
    input  logic          ptw_ack_i,
    input  logic          pte_leaf_i,
    input  logic          pte_fault_i,
    output logic          level2_o,
    output logic          capture_o,
    output logic          pte_load_o,
    output logic          ptw_req_o,
    output ptw_addr_sel_e ptw_addr_sel_o,
    output paddr_sel_e    paddr_sel_o,
    output logic          translate_done_o,
    output logic          page_fault_o
);

    ptw_state_e state_q;
    ptw_state_e state_d;

    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            state_q <= IDLE;
        else
            state_q <= state_d;
    end

    // Checker looks at the level that is being waited on
    assign level2_o = (state_q == LEVEL2_WAIT);

    always_comb begin
        state_d          = state_q;
        capture_o        = 1'b0;
        pte_load_o       = 1'b0;
        ptw_req_o        = 1'b0;
        ptw_addr_sel_o   = ROOT_LIVE;
        paddr_sel_o      = PADDR_BARE;
        translate_done_o = 1'b0;
        page_fault_o     = 1'b0;

        case (state_q)
            IDLE: begin
                if (translate_req_i) begin
                    if (!paging_enabled_i) begin
                        // Bare mode done in the request cycle
                        translate_done_o = 1'b1;
                    end else begin
                        // Root read goes out from the live vaddr
                        capture_o      = 1'b1;
                        ptw_req_o      = 1'b1;
                        ptw_addr_sel_o = ROOT_LIVE;
                        state_d        = LEVEL1_WAIT;
                    end
                end
            end

            LEVEL1_WAIT: begin
                if (!ptw_ack_i) begin
                    // Hold the root read
                    ptw_req_o      = 1'b1;
                    ptw_addr_sel_o = ROOT_SAVED;
                end else if (pte_fault_i) begin
                    state_d = FAULT;
                end else if (pte_leaf_i) begin
                    // 4 MB superpage
                    translate_done_o = 1'b1;
                    paddr_sel_o      = PADDR_SUPER;
                    state_d          = IDLE;
                end else begin
                    // Pointer, next read straight from ptw_data
                    pte_load_o     = 1'b1;
                    ptw_req_o      = 1'b1;
                    ptw_addr_sel_o = NEXT_LIVE;
                    state_d        = LEVEL2_WAIT;
                end
            end

            LEVEL2_WAIT: begin
                if (!ptw_ack_i) begin
                    ptw_req_o      = 1'b1;
                    ptw_addr_sel_o = NEXT_SAVED;
                end else if (pte_fault_i) begin
                    state_d = FAULT;
                end else begin
                    // Checker already rejects pointers here
                    translate_done_o = 1'b1;
                    paddr_sel_o      = PADDR_PAGE;
                    state_d          = IDLE;
                end
            end

            FAULT: begin
                // One cycle report, cause comes from the datapath
                translate_done_o = 1'b1;
                page_fault_o     = 1'b1;
                state_d          = IDLE;
            end

            default: begin
                state_d = IDLE;
            end
        endcase
    end

endmodule

//--- design/sv32_mmu.sv
`timescale 1ns/1ps

`include "mmu_macros.svh"

module sv32_mmu
    import mmu_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    // Translation request
    input  logic                  translate_req_i,
    input  logic [`MMU_XLEN-1:0]  vaddr_i,
    input  logic                  is_write_i,
    input  logic                  is_execute_i,
    input  priv_e                 priv_i,
    // satp state
    input  logic                  paging_enabled_i,
    input  logic [`MMU_PPN_W-1:0] satp_ppn_i,
    // Translation result
    output logic [`MMU_XLEN-1:0]  paddr_o,
    output logic                  translate_done_o,
    output logic                  page_fault_o,
    output logic [3:0]            fault_type_o,
    // Page table memory port
    output logic [`MMU_XLEN-1:0]  ptw_addr_o,
    output logic                  ptw_req_o,
    input  logic [`MMU_XLEN-1:0]  ptw_data_i,
    input  logic                  ptw_ack_i
);

    logic          level2;
    logic          capture;
    logic          pte_load;
    logic          pte_leaf;
    logic          pte_fault;
    ptw_addr_sel_e ptw_addr_sel;
    paddr_sel_e    paddr_sel;
    logic          saved_write;
    logic          saved_execute;
    priv_e         saved_priv;
    fault_code_e   fault_code;

    ptw_fsm u_ptw_fsm (
        .clk              (clk),
        .rst              (rst),
        .translate_req_i  (translate_req_i),
        .paging_enabled_i (paging_enabled_i),
        .ptw_ack_i        (ptw_ack_i),
        .pte_leaf_i       (pte_leaf),
        .pte_fault_i      (pte_fault),
        .level2_o         (level2),
        .capture_o        (capture),
        .pte_load_o       (pte_load),
        .ptw_req_o        (ptw_req_o),
        .ptw_addr_sel_o   (ptw_addr_sel),
        .paddr_sel_o      (paddr_sel),
        .translate_done_o (translate_done_o),
        .page_fault_o     (page_fault_o)
    );

    walk_datapath u_walk_datapath (
        .clk             (clk),
        .rst             (rst),
        .capture_i       (capture),
        .pte_load_i      (pte_load),
        .ptw_addr_sel_i  (ptw_addr_sel),
        .paddr_sel_i     (paddr_sel),
        .vaddr_i         (vaddr_i),
        .is_write_i      (is_write_i),
        .is_execute_i    (is_execute_i),
        .priv_i          (priv_i),
        .satp_ppn_i      (satp_ppn_i),
        .ptw_data_i      (ptw_data_i),
        .ptw_addr_o      (ptw_addr_o),
        .paddr_o         (paddr_o),
        .saved_write_o   (saved_write),
        .saved_execute_o (saved_execute),
        .saved_priv_o    (saved_priv),
        .fault_code_o    (fault_code)
    );

    // Judged against the access captured at request time
    pte_checker u_pte_checker (
        .pte_i        (ptw_data_i),
        .level2_i     (level2),
        .priv_i       (saved_priv),
        .is_write_i   (saved_write),
        .is_execute_i (saved_execute),
        .pte_leaf_o   (pte_leaf),
        .pte_fault_o  (pte_fault)
    );

    assign fault_type_o = fault_code;

endmodule

//--- design/walk_datapath.sv
`timescale 1ns/1ps

`include "mmu_macros.svh"

module walk_datapath
    import mmu_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  capture_i,
    input  logic                  pte_load_i,
    input  ptw_addr_sel_e         ptw_addr_sel_i,
    input  paddr_sel_e            paddr_sel_i,
    input  logic [`MMU_XLEN-1:0]  vaddr_i,
    input  logic                  is_write_i,
    input  logic                  is_execute_i,
    input  priv_e                 priv_i,
    input  logic [`MMU_PPN_W-1:0] satp_ppn_i,
    input  logic [`MMU_XLEN-1:0]  ptw_data_i,
    output logic [`MMU_XLEN-1:0]  ptw_addr_o,
    output logic [`MMU_XLEN-1:0]  paddr_o,
    output logic                  saved_write_o,
    output logic                  saved_execute_o,
    output priv_e                 saved_priv_o,
    output fault_code_e           fault_code_o
);

    // Sv32 physical space is 34 bits wide
    localparam int PA_W     = `MMU_PPN_W + `MMU_OFFSET_W;
    localparam int PPN_LSB  = `MMU_XLEN - `MMU_PPN_W;
    localparam int VPN0_LSB = `MMU_OFFSET_W;
    localparam int VPN1_LSB = `MMU_OFFSET_W + `MMU_VPN_W;
    // Superpage keeps only PPN[1] from the PTE
    localparam int SUPER_W  = `MMU_PPN_W - `MMU_VPN_W;

    logic [`MMU_XLEN-1:0]  saved_vaddr_q;
    logic [`MMU_PPN_W-1:0] saved_ppn_q;
    logic                  saved_write_q;
    logic                  saved_execute_q;
    priv_e                 saved_priv_q;
    logic [`MMU_PPN_W-1:0] base_ppn;
    logic [`MMU_VPN_W-1:0] vpn;
    logic [PA_W-1:0]       walk_addr;
    logic [PA_W-1:0]       paddr_full;

    // Access descriptor of the walk in flight
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            saved_write_q   <= 1'b0;
            saved_execute_q <= 1'b0;
            saved_priv_q    <= PRIV_U;
        end else if (capture_i) begin
            saved_write_q   <= is_write_i;
            saved_execute_q <= is_execute_i;
            saved_priv_q    <= priv_i;
        end
    end

    // Virtual address and level 1 pointer
    always_ff @(posedge clk) begin
        if (capture_i)
            saved_vaddr_q <= vaddr_i;
        if (pte_load_i)
            saved_ppn_q <= ptw_data_i[PPN_LSB +: `MMU_PPN_W];
    end

    // Live sources cover the cycle before the registers fill
    always_comb begin
        base_ppn = satp_ppn_i;
        vpn      = saved_vaddr_q[VPN1_LSB +: `MMU_VPN_W];
        case (ptw_addr_sel_i)
            ROOT_LIVE:  vpn = vaddr_i[VPN1_LSB +: `MMU_VPN_W];
            ROOT_SAVED: vpn = saved_vaddr_q[VPN1_LSB +: `MMU_VPN_W];
            NEXT_LIVE: begin
                base_ppn = ptw_data_i[PPN_LSB +: `MMU_PPN_W];
                vpn      = saved_vaddr_q[VPN0_LSB +: `MMU_VPN_W];
            end
            NEXT_SAVED: begin
                base_ppn = saved_ppn_q;
                vpn      = saved_vaddr_q[VPN0_LSB +: `MMU_VPN_W];
            end
            default: vpn = saved_vaddr_q[VPN1_LSB +: `MMU_VPN_W];
        endcase
    end

    // Table base plus index times PTE size
    assign walk_addr = {base_ppn, {`MMU_OFFSET_W{1'b0}}}
                     + {{(PA_W - `MMU_VPN_W - `MMU_PTE_SHIFT){1'b0}}, vpn,
                        {`MMU_PTE_SHIFT{1'b0}}};
    // Bus only carries the low 32 bits
    assign ptw_addr_o = walk_addr[`MMU_XLEN-1:0];

    // Leaf PPN comes straight from the acked PTE
    always_comb begin
        case (paddr_sel_i)
            PADDR_SUPER: paddr_full = {ptw_data_i[`MMU_XLEN-1 -: SUPER_W],
                                       saved_vaddr_q[VPN0_LSB +: `MMU_VPN_W],
                                       saved_vaddr_q[`MMU_OFFSET_W-1:0]};
            PADDR_PAGE:  paddr_full = {ptw_data_i[PPN_LSB +: `MMU_PPN_W],
                                       saved_vaddr_q[`MMU_OFFSET_W-1:0]};
            default:     paddr_full = {{(PA_W - `MMU_XLEN){1'b0}}, vaddr_i};
        endcase
    end
    assign paddr_o = paddr_full[`MMU_XLEN-1:0];

    assign saved_write_o   = saved_write_q;
    assign saved_execute_o = saved_execute_q;
    assign saved_priv_o    = saved_priv_q;

    // Fetch wins over store, load otherwise
    always_comb begin
        if (saved_execute_q)
            fault_code_o = FAULT_INST;
        else if (saved_write_q)
            fault_code_o = FAULT_STORE;
        else
            fault_code_o = FAULT_LOAD;
    end

endmodule

//--- flist.f
+incdir+design
design/mmu_pkg.sv
design/pte_checker.sv
design/walk_datapath.sv
design/ptw_fsm.sv
design/sv32_mmu.sv
verif/sv32_mmu_tb.sv

//--- verif/sv32_mmu_tb.sv
`timescale 1ns/1ps

`include "mmu_macros.svh"

module sv32_mmu_tb
    import mmu_pkg::*;
();

    localparam int NUM_ROWS = 17;
    // Worst case per row is two reads of up to 9 cycles plus overhead
    localparam int CYCLE_LIMIT = NUM_ROWS * (2 * 9 + 6) + 100;
    localparam logic [`MMU_PPN_W-1:0] SATP_PPN = 22'h00100;
    localparam logic [31:0] LFSR_SEED = 32'h2487_8d94;

    // Access kinds in the table
    localparam logic [1:0] ACC_LOAD  = 2'd0;
    localparam logic [1:0] ACC_STORE = 2'd1;
    localparam logic [1:0] ACC_FETCH = 2'd2;

    typedef struct packed {
        logic                 paging;
        logic [`MMU_XLEN-1:0] vaddr;
        logic [1:0]           acc;
        priv_e                priv;
        logic [`MMU_XLEN-1:0] pte1;
        logic [`MMU_XLEN-1:0] pte2;
        logic [`MMU_XLEN-1:0] exp_paddr;
        logic                 exp_fault;
        logic [3:0]           exp_cause;
        int                   exp_reads;
    } row_t;

    logic                  clk;
    logic                  rst;
    logic                  translate_req_i;
    logic [`MMU_XLEN-1:0]  vaddr_i;
    logic                  is_write_i;
    logic                  is_execute_i;
    priv_e                 priv_i;
    logic                  paging_enabled_i;
    logic [`MMU_PPN_W-1:0] satp_ppn_i;
    logic [`MMU_XLEN-1:0]  paddr_o;
    logic                  translate_done_o;
    logic                  page_fault_o;
    logic [3:0]            fault_type_o;
    logic [`MMU_XLEN-1:0]  ptw_addr_o;
    logic                  ptw_req_o;
    logic [`MMU_XLEN-1:0]  ptw_data_i;
    logic                  ptw_ack_i;

    row_t        rows [NUM_ROWS];
    row_t        cur;
    int          reads;
    int          cycles = 0;
    logic [31:0] lfsr;

    sv32_mmu i_sv32_mmu (
        .clk              (clk),
        .rst              (rst),
        .translate_req_i  (translate_req_i),
        .vaddr_i          (vaddr_i),
        .is_write_i       (is_write_i),
        .is_execute_i     (is_execute_i),
        .priv_i           (priv_i),
        .paging_enabled_i (paging_enabled_i),
        .satp_ppn_i       (satp_ppn_i),
        .paddr_o          (paddr_o),
        .translate_done_o (translate_done_o),
        .page_fault_o     (page_fault_o),
        .fault_type_o     (fault_type_o),
        .ptw_addr_o       (ptw_addr_o),
        .ptw_req_o        (ptw_req_o),
        .ptw_data_i       (ptw_data_i),
        .ptw_ack_i        (ptw_ack_i)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic random_bits(input int n, output logic [2:0] val);
        val = '0;
        repeat (n) begin
            lfsr = lfsr_step(lfsr);
            val  = {val[1:0], lfsr[0]};
        end
    endtask

    task automatic compare(input logic [31:0] actual, input logic [31:0] expected,
                           input string what);
        if (actual !== expected) begin
            $display("Fail %0t ns: %s is %h, expected %h", $time, what, actual, expected);
            $display("Test failed");
            $fatal(1, "Stopping at first mismatch");
        end
    endtask

    // Columns: paging, vaddr, access, priv, level-1 PTE, level-2 PTE
    // then expected paddr, fault, cause, number of memory reads
    task automatic fill_table();
        // Bare mode
        rows[0]  = '{1'b0, 32'h1234_5678, ACC_LOAD,  PRIV_S, 32'h0, 32'h0,
                     32'h1234_5678, 1'b0, 4'd0, 0};
        rows[1]  = '{1'b0, 32'hDEAD_BEEC, ACC_STORE, PRIV_U, 32'h0, 32'h0,
                     32'hDEAD_BEEC, 1'b0, 4'd0, 0};
        // 4 KB page through a pointer
        rows[2]  = '{1'b1, 32'h0112_3456, ACC_LOAD,  PRIV_S, 32'h0008_0001, 32'h048D_1407,
                     32'h1234_5456, 1'b0, 4'd0, 2};
        // Aligned superpage, one read
        rows[3]  = '{1'b1, 32'h282B_C0F0, ACC_FETCH, PRIV_S, 32'h0C30_000B, 32'h0,
                     32'h30EB_C0F0, 1'b0, 4'd0, 1};
        // Invalid at level 1, then at level 2
        rows[4]  = '{1'b1, 32'h0040_0000, ACC_FETCH, PRIV_U, 32'h0, 32'h0,
                     32'h0, 1'b1, 4'd12, 1};
        rows[5]  = '{1'b1, 32'h0112_3000, ACC_STORE, PRIV_S, 32'h0008_0001, 32'h048D_1406,
                     32'h0, 1'b1, 4'd15, 2};
        // Misaligned superpage
        rows[6]  = '{1'b1, 32'h0800_0000, ACC_LOAD,  PRIV_S, 32'h0C30_0403, 32'h0,
                     32'h0, 1'b1, 4'd13, 1};
        // Pointer where a leaf is needed
        rows[7]  = '{1'b1, 32'h0112_3456, ACC_LOAD,  PRIV_S, 32'h0008_0001, 32'h048D_1401,
                     32'h0, 1'b1, 4'd13, 2};
        // W without R, reserved
        rows[8]  = '{1'b1, 32'h0112_3456, ACC_STORE, PRIV_S, 32'h0008_0001, 32'h048D_140D,
                     32'h0, 1'b1, 4'd15, 2};
        // Permission faults on a read-only supervisor page
        rows[9]  = '{1'b1, 32'h0112_3456, ACC_LOAD,  PRIV_U, 32'h0008_0001, 32'h048D_1403,
                     32'h0, 1'b1, 4'd13, 2};
        rows[10] = '{1'b1, 32'h0112_3456, ACC_STORE, PRIV_S, 32'h0008_0001, 32'h048D_1403,
                     32'h0, 1'b1, 4'd15, 2};
        rows[11] = '{1'b1, 32'h0112_3456, ACC_FETCH, PRIV_S, 32'h0008_0001, 32'h048D_1403,
                     32'h0, 1'b1, 4'd12, 2};
        // S on a U page and M loads pass
        rows[12] = '{1'b1, 32'h0112_3456, ACC_LOAD,  PRIV_S, 32'h0008_0001, 32'h048D_1413,
                     32'h1234_5456, 1'b0, 4'd0, 2};
        rows[13] = '{1'b1, 32'h0112_3456, ACC_LOAD,  PRIV_M, 32'h0008_0001, 32'h048D_1403,
                     32'h1234_5456, 1'b0, 4'd0, 2};
        rows[14] = '{1'b1, 32'h0112_3ABC, ACC_FETCH, PRIV_U, 32'h0008_0001, 32'h048D_1419,
                     32'h1234_5ABC, 1'b0, 4'd0, 2};
        rows[15] = '{1'b1, 32'h282B_C0F0, ACC_STORE, PRIV_U, 32'h0C30_0017, 32'h0,
                     32'h30EB_C0F0, 1'b0, 4'd0, 1};
        rows[16] = '{1'b0, 32'h8000_0004, ACC_FETCH, PRIV_M, 32'h0, 32'h0,
                     32'h8000_0004, 1'b0, 4'd0, 0};
    endtask

    // Page-table memory answering one read at a time after a random wait
    initial begin
        logic [31:0] next_addr;
        logic [31:0] exp_addr;
        logic [31:0] data;
        logic [2:0]  wait_cycles;
        ptw_ack_i  = 1'b0;
        ptw_data_i = '0;
        forever begin
            @(posedge clk);
            if (!rst && ptw_req_o) begin
                reads = reads + 1;
                next_addr = 32'({cur.pte1[31:10], 12'h000} + {cur.vaddr[21:12], 2'b00});
                // Level 1 from satp, level 2 from the pointer PTE
                if (reads == 1) begin
                    exp_addr = 32'({satp_ppn_i, 12'h000} + {cur.vaddr[31:22], 2'b00});
                    data     = cur.pte1;
                end else begin
                    exp_addr = next_addr;
                    data     = cur.pte2;
                end
                compare(ptw_addr_o, exp_addr, $sformatf("read %0d address", reads));
                random_bits(3, wait_cycles);
                repeat (wait_cycles) begin
                    @(posedge clk);
                    compare(ptw_req_o, 1'b1, "request held while waiting");
                    compare(ptw_addr_o, exp_addr, "address held while waiting");
                end
                @(negedge clk);
                ptw_ack_i  = 1'b1;
                ptw_data_i = data;
                @(posedge clk);
                // Pointer PTE drives the level 2 read already in its ack cycle
                if (ptw_req_o)
                    compare(ptw_addr_o, next_addr, "read 2 address in the ack cycle");
                @(negedge clk);
                ptw_ack_i  = 1'b0;
                ptw_data_i = '0;
            end
        end
    end

    task automatic run_row(input int idx);
        int          waited;
        logic [31:0] got_paddr;
        logic        got_fault;
        logic [3:0]  got_cause;
        cur    = rows[idx];
        reads  = 0;
        waited = 0;
        @(negedge clk);
        paging_enabled_i = cur.paging;
        vaddr_i          = cur.vaddr;
        is_write_i       = (cur.acc == ACC_STORE);
        is_execute_i     = (cur.acc == ACC_FETCH);
        priv_i           = cur.priv;
        translate_req_i  = 1'b1;
        do begin
            @(posedge clk);
            waited = waited + 1;
        end while (!translate_done_o);
        got_paddr = paddr_o;
        got_fault = page_fault_o;
        got_cause = fault_type_o;
        @(negedge clk);
        translate_req_i = 1'b0;
        compare(got_fault, cur.exp_fault, $sformatf("row %0d page fault", idx));
        if (cur.exp_fault)
            compare(got_cause, cur.exp_cause, $sformatf("row %0d cause", idx));
        else
            compare(got_paddr, cur.exp_paddr, $sformatf("row %0d paddr", idx));
        compare(reads, cur.exp_reads, $sformatf("row %0d memory reads", idx));
        // Bare result lands in the request cycle
        if (!cur.paging)
            compare(waited, 1, $sformatf("row %0d bare latency", idx));
    endtask

    initial begin
        rst              = 1'b1;
        translate_req_i  = 1'b0;
        vaddr_i          = '0;
        is_write_i       = 1'b0;
        is_execute_i     = 1'b0;
        priv_i           = PRIV_M;
        paging_enabled_i = 1'b0;
        satp_ppn_i       = SATP_PPN;
        lfsr             = LFSR_SEED;
        reads            = 0;
        fill_table();
        cur = rows[0];
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        @(posedge clk);
        // Quiet outputs after reset
        compare(ptw_req_o, 1'b0, "ptw_req_o after reset");
        compare(translate_done_o, 1'b0, "translate_done_o after reset");
        compare(page_fault_o, 1'b0, "page_fault_o after reset");
        for (int i = 0; i < NUM_ROWS; i++)
            run_row(i);
        $display("Test passed");
        $finish;
    end

    // Run limit
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: translations did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Test failed");
            $fatal(1, "Run aborted");
        end
    end

endmodule
